/* src/avt_settings.svh */
// bus widths and wait-state cycle counts of the translator, include wherever a width is needed
`ifndef AVT_SETTINGS_SVH
`define AVT_SETTINGS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define AVT_UAV_ADDR_W 16        // fabric byte address
`define AVT_AV_ADDR_W 14         // slave word address
`define AVT_DATA_W 32
`define AVT_BE_W 4

// low address bits that select a byte in the word
`define AVT_SYMBOL_BITS 2

// ----------------------------------------
// slave timing
// ----------------------------------------
`define AVT_SETUP_CYCLES 1
`define AVT_READ_WAIT_CYCLES 2
`define AVT_WRITE_WAIT_CYCLES 1
`define AVT_HOLD_CYCLES 1

// cycles from the accepting edge to valid slave readdata
`define AVT_READ_LATENCY 2

// wide enough for setup + write wait + hold
`define AVT_COUNT_W 3

`endif

/* src/avt_pkg.sv */
// command and operation types shared by the translator blocks and the checker
`include "avt_settings.svh"

package avt_pkg;

   // ----------------------------------------
   // operation decoded from a fabric command
   // ----------------------------------------
   typedef enum logic [1:0] {
      OP_IDLE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } av_op_e;

   // one data word, fabric and slave are the same width
   typedef logic [`AVT_DATA_W-1:0] avt_data_t;

   // ----------------------------------------
   // fabric side command, byte addressed
   // ----------------------------------------
   typedef struct packed {
      logic [`AVT_UAV_ADDR_W-1:0] address;   // byte address
      avt_data_t                  writedata;
      logic [`AVT_BE_W-1:0]       byteenable;
      logic                       read;
      logic                       write;
   } uav_cmd_t;

   // ----------------------------------------
   // slave side command, strobes travel separately
   // ----------------------------------------
   typedef struct packed {
      logic [`AVT_AV_ADDR_W-1:0] address;    // word address
      avt_data_t                 writedata;
      logic [`AVT_BE_W-1:0]      byteenable;
      logic [`AVT_BE_W-1:0]      writebyteenable;
   } av_cmd_t;

endpackage

/* src/command_mapper.sv */
// maps a fabric command onto the slave word bus and marks its first cycle with begintransfer
`include "avt_settings.svh"

module command_mapper
   import avt_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  uav_cmd_t uav_cmd,
   input  logic     uav_waitrequest,
   output av_cmd_t  av_cmd,
   output av_op_e   op,
   output logic     av_begintransfer
);

   logic begun;   // first cycle of the pending command already seen

   // ----------------------------------------
   // address and byte enables
   // ----------------------------------------
   always_comb begin
      av_cmd.address         = uav_cmd.address[`AVT_UAV_ADDR_W-1:`AVT_SYMBOL_BITS];
      av_cmd.writedata       = uav_cmd.writedata;
      av_cmd.byteenable      = uav_cmd.byteenable;
      // only lanes of a write are driven to the slave
      av_cmd.writebyteenable = {`AVT_BE_W{uav_cmd.write}} & uav_cmd.byteenable;
   end

   // ----------------------------------------
   // operation decode
   // ----------------------------------------
   always_comb begin
      if (uav_cmd.write) begin
         op = OP_WRITE;      // write wins if both are set
      end else if (uav_cmd.read) begin
         op = OP_READ;
      end else begin
         op = OP_IDLE;
      end
   end

   // ----------------------------------------
   // begintransfer
   // ----------------------------------------
   assign av_begintransfer = (op != OP_IDLE) && !begun;

   // set on the first waiting cycle, held until the command is taken
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begun <= 1'b0;
      end else if (!uav_waitrequest || op == OP_IDLE) begin
         begun <= 1'b0;    // accepted or nothing pending
      end else if (av_begintransfer) begin
         begun <= 1'b1;
      end
   end

endmodule

/* src/wait_state_timer.sv */
// counts setup, wait and hold cycles of the current command and generates waitrequest and strobes
`include "avt_settings.svh"

module wait_state_timer
   import avt_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  av_op_e op,
   output logic   av_read,
   output logic   av_write,
   output logic   uav_waitrequest,
   output logic   accept
);

   // ----------------------------------------
   // cycle indices within a command
   // ----------------------------------------
   localparam int SETUP_IDX = `AVT_SETUP_CYCLES;
   localparam int READ_IDX  = `AVT_SETUP_CYCLES + `AVT_READ_WAIT_CYCLES;
   localparam int WRITE_IDX = `AVT_SETUP_CYCLES + `AVT_WRITE_WAIT_CYCLES;
   localparam int HOLD_IDX  = WRITE_IDX + `AVT_HOLD_CYCLES;

   localparam logic [`AVT_COUNT_W-1:0] SETUP_END = `AVT_COUNT_W'(SETUP_IDX);
   localparam logic [`AVT_COUNT_W-1:0] READ_END  = `AVT_COUNT_W'(READ_IDX);
   localparam logic [`AVT_COUNT_W-1:0] WRITE_END = `AVT_COUNT_W'(WRITE_IDX);
   localparam logic [`AVT_COUNT_W-1:0] HOLD_END  = `AVT_COUNT_W'(HOLD_IDX);

   logic [`AVT_COUNT_W-1:0] wait_count;   // cycles the command has waited
   logic                    reset_override;
   logic                    wait_gen;     // waitrequest from the count alone

   // ----------------------------------------
   // counter and reset override
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_count     <= '0;
         reset_override <= 1'b1;   // hold off the fabric one cycle
      end else begin
         reset_override <= 1'b0;
         if (reset_override || accept || op == OP_IDLE) begin
            wait_count <= '0;
         end else begin
            wait_count <= wait_count + 1'b1;
         end
      end
   end

   // ----------------------------------------
   // waitrequest
   // ----------------------------------------
   always_comb begin
      case (op)
         OP_READ:  wait_gen = (wait_count != READ_END);
         OP_WRITE: wait_gen = (wait_count != HOLD_END);
         default:  wait_gen = 1'b1;          // nothing to accept
      endcase
   end

   assign uav_waitrequest = wait_gen || reset_override;
   assign accept          = (op != OP_IDLE) && !uav_waitrequest;

   // ----------------------------------------
   // slave strobes
   // ----------------------------------------
   // read stays up through the accepting cycle, write drops before hold
   assign av_read  = (op == OP_READ) && !reset_override && (wait_count >= SETUP_END);
   assign av_write = (op == OP_WRITE) && !reset_override &&
                     (wait_count >= SETUP_END) && (wait_count <= WRITE_END);

endmodule

/* src/read_latency_tracker.sv */
// tracks accepted reads through the fixed slave latency and returns readdatavalid with the data
`include "avt_settings.svh"

module read_latency_tracker
   import avt_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  av_op_e    op,
   input  logic      accept,
   input  avt_data_t av_readdata,
   output logic      uav_readdatavalid,
   output avt_data_t uav_readdata
);

   localparam int LAT = `AVT_READ_LATENCY;

   // one bit per cycle of latency, bit 0 is the newest read
   logic [LAT-1:0] read_pipe;
   logic           read_taken;

   // ----------------------------------------
   // load and advance
   // ----------------------------------------
   assign read_taken = accept && (op == OP_READ);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_pipe <= '0;
      end else begin
         read_pipe[0] <= read_taken;
         for (int i = 1; i < LAT; i++) begin
            read_pipe[i] <= read_pipe[i-1];   // no stall on the return path
         end
      end
   end

   // ----------------------------------------
   // return to fabric
   // ----------------------------------------
   assign uav_readdatavalid = read_pipe[LAT-1];

   // slave holds data in the valid cycle
   assign uav_readdata = av_readdata;

endmodule

/* src/avt_translator.sv */
// top level of the fabric to fixed-timing slave translator, connects mapper, timer and tracker
`include "avt_settings.svh"

module avt_translator
   import avt_pkg::*;
(
   input  logic      clk,
   input  logic      reset,

   // ----------------------------------------
   // fabric side
   // ----------------------------------------
   input  uav_cmd_t  uav_cmd,
   output logic      uav_waitrequest,
   output logic      uav_readdatavalid,
   output avt_data_t uav_readdata,

   // ----------------------------------------
   // slave side
   // ----------------------------------------
   output av_cmd_t   av_cmd,
   output logic      av_read,
   output logic      av_write,
   output logic      av_begintransfer,
   input  avt_data_t av_readdata
);

   av_op_e op;       // decoded operation of the pending command
   logic   accept;   // command taken this cycle

   command_mapper u_command_mapper (
      .clk              (clk),
      .reset            (reset),
      .uav_cmd          (uav_cmd),
      .uav_waitrequest  (uav_waitrequest),
      .av_cmd           (av_cmd),
      .op               (op),
      .av_begintransfer (av_begintransfer)
   );

   wait_state_timer u_wait_state_timer (
      .clk             (clk),
      .reset           (reset),
      .op              (op),
      .av_read         (av_read),
      .av_write        (av_write),
      .uav_waitrequest (uav_waitrequest),
      .accept          (accept)
   );

   // read return runs beside the timer
   read_latency_tracker u_read_latency_tracker (
      .clk               (clk),
      .reset             (reset),
      .op                (op),
      .accept            (accept),
      .av_readdata       (av_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata)
   );

endmodule

/* tb/avt_clock_gen.sv */
// clock and power-on reset source for the translator testbench, 40 ns period and 3-cycle reset
module avt_clock_gen (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   // release on a falling edge so the first rising edge sees a clean low
   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

/* tb/avt_checker.sv */
// concurrent assertions on the translator top level, attached to avt_translator by bind
`include "avt_settings.svh"

module avt_checker
   import avt_pkg::*;
(
   input logic     clk,
   input logic     reset,
   input uav_cmd_t uav_cmd,
   input logic     uav_waitrequest,
   input logic     uav_readdatavalid,
   input logic     av_read,
   input logic     av_write,
   input logic     av_begintransfer
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WRITE_LEN = `AVT_WRITE_WAIT_CYCLES + 1;   // cycles av_write stays up

   int unsigned assert_errors = 0;
   int          write_run;    // consecutive av_write cycles before this one
   logic        cmd_valid;
   logic        read_taken;

   assign cmd_valid  = uav_cmd.read || uav_cmd.write;
   assign read_taken = uav_cmd.read && !uav_cmd.write && !uav_waitrequest;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         write_run <= 0;
      end else if (av_write) begin
         write_run <= write_run + 1;
      end else begin
         write_run <= 0;
      end
   end

   // ----------------------------------------
   // reset state
   // ----------------------------------------
   reset_state_a: assert property (@(posedge clk)
      (reset || $fell(reset)) |-> uav_waitrequest && !av_read && !av_write && !uav_readdatavalid)
      else begin
         assert_errors++;
         $error("slave strobes or waitrequest wrong during or right after reset");
      end

   // ----------------------------------------
   // begintransfer, once per command
   // ----------------------------------------
   begin_first_a: assert property (@(posedge clk) disable iff (reset)
      (cmd_valid && (!$past(cmd_valid) || !$past(uav_waitrequest))) |-> av_begintransfer)
      else begin
         assert_errors++;
         $error("begintransfer missing in the first cycle of a command");
      end

   begin_once_a: assert property (@(posedge clk) disable iff (reset)
      (av_begintransfer && uav_waitrequest) |=> !av_begintransfer)
      else begin
         assert_errors++;
         $error("begintransfer high for more than one cycle of a command");
      end

   // ----------------------------------------
   // write strobe window
   // ----------------------------------------
   write_owner_a: assert property (@(posedge clk) disable iff (reset)
      av_write |-> uav_cmd.write && uav_waitrequest)
      else begin
         assert_errors++;
         $error("av_write high outside a waiting write command");
      end

   // strobe starts once the setup cycles have passed
   write_start_a: assert property (@(posedge clk) disable iff (reset)
      $rose(av_write) |-> $past(av_begintransfer, `AVT_SETUP_CYCLES))
      else begin
         assert_errors++;
         $error("av_write did not rise right after the setup cycles");
      end

   write_len_a: assert property (@(posedge clk) disable iff (reset)
      av_write |-> write_run < WRITE_LEN)
      else begin
         assert_errors++;
         $error("av_write high for too many cycles");
      end

   write_end_a: assert property (@(posedge clk) disable iff (reset)
      (!av_write && write_run != 0) |-> write_run == WRITE_LEN)
      else begin
         assert_errors++;
         $error("av_write dropped too early");
      end

   // read return follows the accepting edge by the fixed latency
   read_return_a: assert property (@(posedge clk) disable iff (reset)
      uav_readdatavalid == $past(read_taken, `AVT_READ_LATENCY))
      else begin
         assert_errors++;
         $error("readdatavalid does not follow an accepted read by the read latency");
      end

endmodule

/* tb/avt_tb.sv */
// testbench for the translator that applies a table of fabric commands and checks the results
`include "avt_settings.svh"

module avt_tb
   import avt_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int LAT         = `AVT_READ_LATENCY;
   localparam int READ_EDGES  = `AVT_SETUP_CYCLES + `AVT_READ_WAIT_CYCLES + 1;
   localparam int WRITE_EDGES = `AVT_SETUP_CYCLES + `AVT_WRITE_WAIT_CYCLES +
                                `AVT_HOLD_CYCLES + 1;
   localparam int NUM_ROWS    = 14;
   localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 20;
   localparam int MEM_WORDS   = 16;
   localparam int MEM_AW      = 4;

   typedef struct packed {
      av_op_e                     op;
      logic [`AVT_UAV_ADDR_W-1:0] addr;    // byte address
      avt_data_t                  wdata;
      logic [`AVT_BE_W-1:0]       be;
      avt_data_t                  exp_rdata;
   } row_t;

   logic        clk;
   logic        reset;
   uav_cmd_t    uav_cmd;
   logic        uav_waitrequest;
   logic        uav_readdatavalid;
   avt_data_t   uav_readdata;
   av_cmd_t     av_cmd;
   logic        av_read;
   logic        av_write;
   logic        av_begintransfer;
   avt_data_t   av_readdata;

   row_t        stim [NUM_ROWS];
   integer      seed = 32'he417a58f;
   int unsigned cycle = 0;
   int unsigned due_q [$];    // edge that must see readdatavalid
   avt_data_t   data_q [$];

   avt_clock_gen u_clock_gen (.clk(clk), .reset(reset));

   avt_translator dut (
      .clk               (clk),
      .reset             (reset),
      .uav_cmd           (uav_cmd),
      .uav_waitrequest   (uav_waitrequest),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata),
      .av_cmd            (av_cmd),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_begintransfer  (av_begintransfer),
      .av_readdata       (av_readdata)
   );

   bind avt_translator avt_checker u_avt_checker (
      .clk               (clk),
      .reset             (reset),
      .uav_cmd           (uav_cmd),
      .uav_waitrequest   (uav_waitrequest),
      .uav_readdatavalid (uav_readdatavalid),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_begintransfer  (av_begintransfer)
   );

   always @(posedge clk) cycle <= cycle + 1;

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic avt_data_t fill_word(input int idx);
      return {8'hA5, 4'(idx), 4'h0, 8'(idx * 7), 8'(~idx)};
   endfunction

   function automatic avt_data_t merge_bytes(input avt_data_t old_word, input avt_data_t new_word,
                                             input logic [`AVT_BE_W-1:0] be);
      avt_data_t result;
      result = old_word;
      for (int b = 0; b < `AVT_BE_W; b++) begin
         if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

   task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
      if (actual !== expected) begin
         $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "mismatch in %s", what);
      end
   endtask

   // ----------------------------------------
   // slave model with fixed latency and no waitrequest
   // ----------------------------------------
   avt_data_t         slave_mem [MEM_WORDS];
   logic [LAT-1:0]    rd_pending;
   logic [MEM_AW-1:0] rd_word [LAT];
   logic              rd_accept;

   assign rd_accept = av_read && !uav_waitrequest;   // the slave is told by the accepting edge

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < MEM_WORDS; i++) slave_mem[i] <= fill_word(i);
         rd_pending <= '0;
         for (int i = 0; i < LAT; i++) rd_word[i] <= '0;
      end else begin
         if (av_write) begin
            slave_mem[av_cmd.address[MEM_AW-1:0]] <= merge_bytes(
               slave_mem[av_cmd.address[MEM_AW-1:0]], av_cmd.writedata, av_cmd.writebyteenable);
         end
         rd_pending[0] <= rd_accept;
         rd_word[0]    <= av_cmd.address[MEM_AW-1:0];
         for (int i = 1; i < LAT; i++) begin
            rd_pending[i] <= rd_pending[i-1];
            rd_word[i]    <= rd_word[i-1];
         end
      end
   end

   assign av_readdata = rd_pending[LAT-1] ? slave_mem[rd_word[LAT-1]] : '0;

   // ----------------------------------------
   // stimulus table
   // ----------------------------------------
   task automatic build_stimulus();
      avt_data_t ref_mem [MEM_WORDS];
      int        w;
      for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = fill_word(i);
      stim[0]  = '{OP_WRITE, 16'h0004, '0, 4'hf, '0};
      stim[1]  = '{OP_READ,  16'h0004, '0, 4'hf, '0};
      stim[2]  = '{OP_WRITE, 16'h0010, '0, 4'hf, '0};
      stim[3]  = '{OP_WRITE, 16'h0012, '0, 4'h5, '0};   // partial write with low address bits set
      stim[4]  = '{OP_READ,  16'h0010, '0, 4'hf, '0};
      stim[5]  = '{OP_READ,  16'h0000, '0, 4'hf, '0};   // untouched fill word
      stim[6]  = '{OP_WRITE, 16'h003c, '0, 4'h8, '0};
      stim[7]  = '{OP_READ,  16'h003f, '0, 4'hf, '0};
      stim[8]  = '{OP_READ,  16'h003c, '0, 4'hf, '0};
      stim[9]  = '{OP_WRITE, 16'h0020, '0, 4'h3, '0};
      stim[10] = '{OP_READ,  16'h0021, '0, 4'hf, '0};
      stim[11] = '{OP_WRITE, 16'h0008, '0, 4'hf, '0};
      stim[12] = '{OP_READ,  16'h0008, '0, 4'hf, '0};
      stim[13] = '{OP_READ,  16'h0004, '0, 4'hf, '0};
      // random write data and expected read words in table order
      for (int i = 0; i < NUM_ROWS; i++) begin
         w = (int'(stim[i].addr) >> `AVT_SYMBOL_BITS) % MEM_WORDS;
         if (stim[i].op == OP_WRITE) begin
            stim[i].wdata = $random(seed);
            ref_mem[w] = merge_bytes(ref_mem[w], stim[i].wdata, stim[i].be);
         end
         stim[i].exp_rdata = ref_mem[w];
      end
   endtask

   // slave side of the command in its accepting cycle
   task automatic check_slave_side(input row_t r);
      logic [`AVT_BE_W-1:0] exp_wbe;
      exp_wbe = (r.op == OP_WRITE) ? r.be : '0;
      compare_value(32'(av_cmd.address), 32'(r.addr) >> `AVT_SYMBOL_BITS, "slave word address");
      compare_value(32'(av_cmd.byteenable), 32'(r.be), "slave byteenable");
      compare_value(32'(av_cmd.writebyteenable), 32'(exp_wbe), "slave writebyteenable");
      compare_value(32'(av_read), 32'(r.op == OP_READ), "av_read in the accepting cycle");
      if (r.op == OP_WRITE) begin
         compare_value(32'(av_cmd.writedata), 32'(r.wdata), "slave writedata");
      end
   endtask

   // called on a falling edge and returns on the falling edge after acceptance
   task automatic apply_command(input row_t r);
      int   edges;
      logic accepted;
      uav_cmd.address    = r.addr;
      uav_cmd.writedata  = r.wdata;
      uav_cmd.byteenable = r.be;
      uav_cmd.read       = (r.op == OP_READ);
      uav_cmd.write      = (r.op == OP_WRITE);
      edges    = 0;
      accepted = 1'b0;
      while (!accepted) begin
         #1;
         accepted = !uav_waitrequest;   // this is what the next rising edge sees
         if (accepted) check_slave_side(r);
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      if (r.op == OP_READ) begin
         compare_value(32'(edges), 32'(READ_EDGES), "cycles to accept a read");
         due_q.push_back(cycle + LAT);
         data_q.push_back(r.exp_rdata);
      end else begin
         compare_value(32'(edges), 32'(WRITE_EDGES), "cycles to accept a write");
      end
   endtask

   task automatic check_read_return();
      logic due_now;
      due_now = (due_q.size() != 0) && (due_q[0] == cycle + 1);
      compare_value(32'(uav_readdatavalid), 32'(due_now), "readdatavalid timing");
      if (due_now) begin
         compare_value(32'(uav_readdata), 32'(data_q[0]), "returned readdata");
         void'(due_q.pop_front());
         void'(data_q.pop_front());
      end
   endtask

   always begin
      @(negedge clk);
      #5;
      check_read_return();
   end

   // ----------------------------------------
   // main sequence and watchdog
   // ----------------------------------------
   initial begin : main_sequence
      uav_cmd = '0;
      build_stimulus();
      @(negedge clk);
      compare_value(32'(uav_waitrequest), 32'd1, "waitrequest during reset");
      compare_value(32'(av_read), 32'd0, "av_read during reset");
      compare_value(32'(av_write), 32'd0, "av_write during reset");
      wait (!reset);
      repeat (2) @(negedge clk);
      compare_value(32'(uav_waitrequest), 32'd1, "waitrequest while idle");
      for (int i = 0; i < NUM_ROWS; i++) begin
         apply_command(stim[i]);
      end
      uav_cmd = '0;
      while (due_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);   // no stray readdatavalid
      if (dut.u_avt_checker.assert_errors == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("%0d assertions in the checker failed", dut.u_avt_checker.assert_errors);
         $display("TEST RESULT: FAIL");
         $fatal(1, "checker assertion failures");
      end
   end

   initial begin : watchdog
      wait (cycle >= CYCLE_LIMIT);
      $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

endmodule

/* avt.f */
+incdir+src
src/avt_pkg.sv
src/command_mapper.sv
src/wait_state_timer.sv
src/read_latency_tracker.sv
src/avt_translator.sv
tb/avt_clock_gen.sv
tb/avt_checker.sv
tb/avt_tb.sv

/* run_sim.sh */
#!/bin/sh
# compiles the translator testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module avt_tb -f avt.f -o avt_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/avt_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST RESULT: PASS"; then
   exit 0
fi

echo "pass line not found in simulation output"
exit 1
